//--- list.f
+incdir+tests
src/div_types_pkg.sv
src/div_ctrl_pkg.sv
src/div_operand_if.sv
src/div_control.sv
src/step_counter.sv
src/div_sign_fix.sv
src/div_datapath.sv
src/mips_divider.sv
tests/tb_mips_divider.sv

//--- run.sh
#!/bin/sh
# Build the divider testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_mips_divider \
    || { echo "Build failed."; exit 1; }

out="$(./obj_dir/Vtb_mips_divider 2>&1)"
echo "$out"

echo "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1

//--- src/div_control.sv
// Divider sequencer
`default_nettype none

module div_control (
    input  logic clk,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic abandon_i,
    input  logic stall_i,
    input  logic last_i,
    output logic load_o,
    output logic step_o,
    output logic fix_o,
    output logic cnt_clr_o,
    output logic cnt_en_o,
    output logic ready_o
);

    import div_ctrl_pkg::*;

    div_state_e state_q;
    div_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start_i) begin
                    state_d = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (last_i) begin
                    state_d = ST_FIX; // Final step runs at this edge.
                end
            end
            ST_FIX: begin
                state_d = ST_DONE;
            end
            ST_DONE: begin
                if (!stall_i) begin
                    state_d = ST_IDLE; // Pipeline has taken the result.
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
        if (abandon_i) begin
            state_d = ST_IDLE; // A flush wins over everything else.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign load_o    = (state_q == ST_IDLE) && start_i && !abandon_i;
    assign step_o    = (state_q == ST_BUSY);
    assign fix_o     = (state_q == ST_FIX);
    assign cnt_clr_o = load_o;    // Counter restarts with each new operation.
    assign cnt_en_o  = step_o;
    assign ready_o   = (state_q == ST_DONE);

    // Each operation iterates for exactly NUM_STEPS cycles before the sign fix.
    a_step_count: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        fix_o |-> ($past(step_o, NUM_STEPS) && !$past(step_o, NUM_STEPS + 1))
    );

endmodule

`default_nettype wire

//--- src/div_ctrl_pkg.sv
// Divider control definitions
`default_nettype none

package div_ctrl_pkg;

    // One restoring step per quotient bit.
    localparam int NUM_STEPS = 32;

    // Step index, 0 to NUM_STEPS-1.
    typedef logic [$clog2(NUM_STEPS)-1:0] step_cnt_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0, // Waiting for start.
        ST_BUSY = 2'd1, // Shift-subtract iterations.
        ST_FIX  = 2'd2, // Sign correction of the raw results.
        ST_DONE = 2'd3  // Result valid, held under stall.
    } div_state_e;

endpackage

`default_nettype wire

//--- src/div_datapath.sv
// Restoring division datapath
`default_nettype none

module div_datapath (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           load_i,
    input  logic           step_i,
    div_operand_if.iter_mp ops
);

    import div_types_pkg::*;

    word_t             rem_q;
    word_t             quot_q;
    word_t             divisor_q;
    logic              loaded_q;
    logic [DATA_W:0]   rem_shift;
    logic [DATA_W:0]   trial;

    // Next dividend bit enters the partial remainder from the quotient register.
    assign rem_shift = {rem_q, quot_q[DATA_W-1]};
    assign trial     = rem_shift - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (load_i) begin
            rem_q     <= '0;
            quot_q    <= ops.dividend_mag;
            divisor_q <= ops.divisor_mag;
        end else if (step_i) begin
            if (!trial[DATA_W]) begin
                rem_q  <= trial[DATA_W-1:0]; // Divisor fits, keep the difference.
                quot_q <= {quot_q[DATA_W-2:0], 1'b1};
            end else begin
                rem_q  <= rem_shift[DATA_W-1:0];
                quot_q <= {quot_q[DATA_W-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            loaded_q <= 1'b0;
        end else if (load_i) begin
            loaded_q <= 1'b1;
        end
    end

    assign ops.quot_raw = quot_q;
    assign ops.rem_raw  = rem_q;

    // Iterating on registers that were never loaded gives garbage.
    a_step_after_load: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        step_i |-> loaded_q
    );

endmodule

`default_nettype wire

//--- src/div_operand_if.sv
// Divider operand channel
`default_nettype none

interface div_operand_if;

    import div_types_pkg::*;

    word_t dividend_mag;
    word_t divisor_mag;
    word_t quot_raw;
    word_t rem_raw;

    // Sign stage side.
    modport sign_mp (
        output dividend_mag,
        output divisor_mag,
        input  quot_raw,
        input  rem_raw
    );

    // Iteration side.
    modport iter_mp (
        input  dividend_mag,
        input  divisor_mag,
        output quot_raw,
        output rem_raw
    );

endinterface

`default_nettype wire

//--- src/div_sign_fix.sv
// Divider sign handling
`default_nettype none

module div_sign_fix (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  load_i,
    input  logic                  fix_i,
    input  logic                  signed_i,
    input  div_types_pkg::word_t  opr1_i,
    input  div_types_pkg::word_t  opr2_i,
    div_operand_if.sign_mp        ops,
    output div_types_pkg::dword_t res_o
);

    import div_types_pkg::*;

    logic   opr1_neg;
    logic   opr2_neg;
    logic   quot_neg_q;
    logic   rem_neg_q;
    word_t  quot_fixed;
    word_t  rem_fixed;
    dword_t res_q;

    // Only signed division treats the top bit as a sign.
    assign opr1_neg = signed_i && opr1_i[DATA_W-1];
    assign opr2_neg = signed_i && opr2_i[DATA_W-1];

    assign ops.dividend_mag = opr1_neg ? word_t'(-opr1_i) : opr1_i;
    assign ops.divisor_mag  = opr2_neg ? word_t'(-opr2_i) : opr2_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            quot_neg_q <= 1'b0;
            rem_neg_q  <= 1'b0;
        end else if (load_i) begin
            quot_neg_q <= opr1_neg ^ opr2_neg; // Signs differ, quotient is negative.
            rem_neg_q  <= opr1_neg;            // Remainder follows the dividend.
        end
    end

    assign quot_fixed = quot_neg_q ? word_t'(-ops.quot_raw) : ops.quot_raw;
    assign rem_fixed  = rem_neg_q ? word_t'(-ops.rem_raw) : ops.rem_raw;

    always_ff @(posedge clk) begin
        if (fix_i) begin
            res_q <= {rem_fixed, quot_fixed}; // HI is remainder, LO is quotient.
        end
    end

    assign res_o = res_q;

endmodule

`default_nettype wire

//--- src/div_types_pkg.sv
// Divider data types
`default_nettype none

package div_types_pkg;

    // Operand width of the divider.
    localparam int DATA_W = 32;

    // One operand, quotient or remainder.
    typedef logic [DATA_W-1:0] word_t;

    // Result word, remainder in the upper half (HI) and quotient in the lower half (LO).
    typedef logic [2*DATA_W-1:0] dword_t;

endpackage

`default_nettype wire

//--- src/mips_divider.sv
// Multi-cycle integer divider
`default_nettype none

module mips_divider (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  start_i,
    input  logic                  abandon_i,
    input  logic                  stall_i,
    input  logic                  signed_i,
    input  div_types_pkg::word_t  opr1_i,
    input  div_types_pkg::word_t  opr2_i,
    output logic                  ready_o,
    output div_types_pkg::dword_t res_o
);

    logic load;
    logic step;
    logic fix;
    logic cnt_clr;
    logic cnt_en;
    logic last;

    div_operand_if ops_if ();

    div_control u_control (
        .clk       (clk      ),
        .rst_n_i   (rst_n_i  ),
        .start_i   (start_i  ),
        .abandon_i (abandon_i),
        .stall_i   (stall_i  ),
        .last_i    (last     ),
        .load_o    (load     ),
        .step_o    (step     ),
        .fix_o     (fix      ),
        .cnt_clr_o (cnt_clr  ),
        .cnt_en_o  (cnt_en   ),
        .ready_o   (ready_o  )
    );

    step_counter u_step_counter (
        .clk     (clk    ),
        .rst_n_i (rst_n_i),
        .clr_i   (cnt_clr),
        .en_i    (cnt_en ),
        .last_o  (last   )
    );

    div_sign_fix u_sign_fix (
        .clk      (clk     ),
        .rst_n_i  (rst_n_i ),
        .load_i   (load    ),
        .fix_i    (fix     ),
        .signed_i (signed_i),
        .opr1_i   (opr1_i  ),
        .opr2_i   (opr2_i  ),
        .ops      (ops_if  ),
        .res_o    (res_o   )
    );

    div_datapath u_datapath (
        .clk     (clk    ),
        .rst_n_i (rst_n_i),
        .load_i  (load   ),
        .step_i  (step   ),
        .ops     (ops_if )
    );

endmodule

`default_nettype wire

//--- src/step_counter.sv
// Iteration step counter
`default_nettype none

module step_counter (
    input  logic clk,
    input  logic rst_n_i,
    input  logic clr_i,
    input  logic en_i,
    output logic last_o
);

    import div_ctrl_pkg::*;

    step_cnt_t cnt_q;

    assign last_o = (cnt_q == step_cnt_t'(NUM_STEPS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else if (clr_i) begin
            cnt_q <= '0;
        end else if (en_i && !last_o) begin
            cnt_q <= cnt_q + step_cnt_t'(1); // Saturates on the final step.
        end
    end

    // Counting must stop once the final step has been taken.
    a_no_wrap: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (en_i && last_o) |=> !en_i
    );

endmodule

`default_nettype wire

//--- tests/tb_div_vectors.svh
// Divider test vectors
`ifndef TB_DIV_VECTORS_SVH
`define TB_DIV_VECTORS_SVH

// Columns: signed flag, dividend, divisor, stall cycles after ready,
// abandon step (-1 for none), expected HI (remainder), expected LO (quotient).
typedef struct packed {
    logic  sgn;
    word_t opa;
    word_t opb;
    int    stall;
    int    abort_at;
    word_t exp_rem;
    word_t exp_quot;
} vec_t;

localparam int NUM_VECTORS = 24;

// Each abandoned row is followed by a row with new operands that must complete.
localparam vec_t VECTORS [NUM_VECTORS] = '{
    '{1'b0, 32'h0000_0064, 32'h0000_0007, 0, -1, 32'h0000_0002, 32'h0000_000E},
    '{1'b0, 32'hFFFF_FFFF, 32'h0000_0001, 0, -1, 32'h0000_0000, 32'hFFFF_FFFF},
    '{1'b0, 32'h8000_0000, 32'h0000_0003, 0, -1, 32'h0000_0002, 32'h2AAA_AAAA},
    '{1'b0, 32'h0000_0005, 32'h0000_0009, 0, -1, 32'h0000_0005, 32'h0000_0000},
    '{1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 0, -1, 32'h0000_0000, 32'h0000_0001},
    '{1'b0, 32'hDEAD_BEEF, 32'h0001_0000, 3, -1, 32'h0000_BEEF, 32'h0000_DEAD},
    '{1'b0, 32'h1234_5678, 32'h8000_0000, 0, -1, 32'h1234_5678, 32'h0000_0000},
    // Signed, all four sign combinations of 7 and 2.
    '{1'b1, 32'h0000_0007, 32'h0000_0002, 0, -1, 32'h0000_0001, 32'h0000_0003},
    '{1'b1, 32'hFFFF_FFF9, 32'h0000_0002, 0, -1, 32'hFFFF_FFFF, 32'hFFFF_FFFD},
    '{1'b1, 32'h0000_0007, 32'hFFFF_FFFE, 0, -1, 32'h0000_0001, 32'hFFFF_FFFD},
    '{1'b1, 32'hFFFF_FFF9, 32'hFFFF_FFFE, 0, -1, 32'hFFFF_FFFF, 32'h0000_0003},
    '{1'b1, 32'h8000_0000, 32'hFFFF_FFFF, 0, -1, 32'h0000_0000, 32'h8000_0000},
    '{1'b1, 32'hFFFF_FF9C, 32'h0000_0007, 2, -1, 32'hFFFF_FFFE, 32'hFFFF_FFF2},
    '{1'b1, 32'h8000_0000, 32'h0000_0003, 0, -1, 32'hFFFF_FFFE, 32'hD555_5556},
    '{1'b1, 32'h0000_03E8, 32'hFFFF_FFDF, 0, -1, 32'h0000_000A, 32'hFFFF_FFE2},
    '{1'b1, 32'hFFFF_FFFB, 32'h0000_0064, 0, -1, 32'hFFFF_FFFB, 32'h0000_0000},
    // Abandon together with start, then a fresh operation.
    '{1'b0, 32'h0000_007B, 32'h0000_0004, 0, 0,  32'h0000_0003, 32'h0000_001E},
    '{1'b0, 32'h0000_0051, 32'h0000_0009, 0, -1, 32'h0000_0000, 32'h0000_0009},
    '{1'b1, 32'hFFFF_FFF7, 32'h0000_0004, 0, 5,  32'hFFFF_FFFF, 32'hFFFF_FFFE},
    '{1'b0, 32'h0000_03E8, 32'h0000_000A, 0, -1, 32'h0000_0000, 32'h0000_0064},
    '{1'b0, 32'h0000_004D, 32'h0000_0007, 0, 32, 32'h0000_0000, 32'h0000_000B},
    '{1'b0, 32'hFFFF_FFF0, 32'h0000_0010, 1, -1, 32'h0000_0000, 32'h0FFF_FFFF},
    // Abandon lands on the sign fix edge.
    '{1'b0, 32'h0000_0003, 32'h0000_0002, 0, 33, 32'h0000_0001, 32'h0000_0001},
    '{1'b1, 32'hFFFF_FFFF, 32'h0000_0001, 4, -1, 32'h0000_0000, 32'hFFFF_FFFF}
};

`endif

//--- tests/tb_mips_divider.sv
// Divider testbench
`default_nettype none

module tb_mips_divider;

    timeunit 1ns;
    timeprecision 1ps;

    import div_types_pkg::*;

    `include "tb_div_vectors.svh"

    localparam int LATENCY       = 34; // Load, 32 steps and the sign fix.
    localparam int READY_TIMEOUT = 100;
    localparam int ABANDON_WAIT  = 40;
    localparam int NUM_RANDOM    = 40;

    logic   clk = 1'b0;
    logic   rst_n_i;
    logic   start_i;
    logic   abandon_i;
    logic   stall_i;
    logic   signed_i;
    word_t  opr1_i;
    word_t  opr2_i;
    logic   ready_o;
    dword_t res_o;
    int     seed;
    vec_t   rand_vec;

    mips_divider UUT (
        .clk       (clk      ),
        .rst_n_i   (rst_n_i  ),
        .start_i   (start_i  ),
        .abandon_i (abandon_i),
        .stall_i   (stall_i  ),
        .signed_i  (signed_i ),
        .opr1_i    (opr1_i   ),
        .opr2_i    (opr2_i   ),
        .ready_o   (ready_o  ),
        .res_o     (res_o    )
    );

    always #5 clk = ~clk;

    task automatic halt_failed();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at time %0d ns: %s", $time, msg);
        halt_failed();
    endtask

    task automatic compare_res(input dword_t got, input dword_t exp, input int row);
        if (got !== exp) begin
            $display("MISMATCH at time %0d ns: res_o (row %0d) got %h expected %h",
                     $time, row, got, exp);
            halt_failed();
        end
    endtask

    task automatic verify_ready(input logic got, input logic exp, input int row);
        if (got !== exp) begin
            $display("MISMATCH at time %0d ns: ready_o (row %0d) got %b expected %b",
                     $time, row, got, exp);
            halt_failed();
        end
    endtask

    // Random operands, expected values from the language's truncating operators.
    task automatic build_random_vector(output vec_t v);
        word_t raw;
        raw        = $random(seed);
        v.sgn      = raw[0];
        v.opa      = $random(seed);
        v.opb      = $random(seed);
        v.stall    = $random(seed) & 3;
        v.abort_at = -1;
        if (v.opb == '0) begin
            v.opb = 32'd1;
        end
        if (v.sgn && v.opa == 32'h8000_0000 && v.opb == 32'hFFFF_FFFF) begin
            v.opb = 32'd3; // Keeps the signed overflow case out of the reference math.
        end
        if (v.sgn) begin
            v.exp_quot = word_t'($signed(v.opa) / $signed(v.opb));
            v.exp_rem  = word_t'($signed(v.opa) % $signed(v.opb));
        end else begin
            v.exp_quot = v.opa / v.opb;
            v.exp_rem  = v.opa % v.opb;
        end
    endtask

    task automatic run_division(input vec_t v, input int row);
        int   edges;
        int   held;
        logic got_ready;
        @(posedge clk);
        signed_i  <= v.sgn;
        opr1_i    <= v.opa;
        opr2_i    <= v.opb;
        start_i   <= 1'b1;
        stall_i   <= (v.stall > 0);
        abandon_i <= (v.abort_at == 0);
        edges     = 0;
        if (v.abort_at >= 0) begin
            while (edges < ABANDON_WAIT) begin
                @(posedge clk);
                edges++;
                start_i   <= 1'b0;
                abandon_i <= (edges == v.abort_at);
                @(negedge clk);
                verify_ready(ready_o, 1'b0, row);
            end
        end else begin
            got_ready = 1'b0;
            while (!got_ready && edges < READY_TIMEOUT) begin
                @(posedge clk);
                edges++;
                start_i <= 1'b0;
                @(negedge clk);
                verify_ready(ready_o, (edges == LATENCY), row);
                got_ready = ready_o;
            end
            if (!got_ready) begin
                report_failure($sformatf("ready_o never rose for row %0d", row));
            end
            compare_res(res_o, {v.exp_rem, v.exp_quot}, row);
            held = 0;
            while (held < v.stall) begin
                @(posedge clk);
                held++;
                if (held == v.stall) begin
                    stall_i <= 1'b0;
                end
                @(negedge clk);
                verify_ready(ready_o, 1'b1, row); // Result held under stall.
                compare_res(res_o, {v.exp_rem, v.exp_quot}, row);
            end
            @(posedge clk);
            @(negedge clk);
            verify_ready(ready_o, 1'b0, row);
        end
    endtask

    initial begin
        seed = 32'h3502_b401;
        rst_n_i   <= 1'b0;
        start_i   <= 1'b0;
        abandon_i <= 1'b0;
        stall_i   <= 1'b0;
        signed_i  <= 1'b0;
        opr1_i    <= '0;
        opr2_i    <= '0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        // Idle with no start must keep ready_o low.
        repeat (5) begin
            @(posedge clk);
            @(negedge clk);
            verify_ready(ready_o, 1'b0, -1);
        end
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_division(VECTORS[i], i);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            build_random_vector(rand_vec);
            run_division(rand_vec, NUM_VECTORS + i);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
